// ==== compile.f ====
+incdir+tb
verilog/rot_bus_pkg.sv
verilog/rot_entropy_pkg.sv
verilog/rot_reg_if.sv
verilog/es_fifo.sv
verilog/entropy_src.sv
verilog/edn.sv
verilog/rot_xbar.sv
verilog/rot_top.sv
tb/rot_top_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f compile.f --top-module rot_top_tb -o Vrot_top_tb

status=0
./obj_dir/Vrot_top_tb > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "TESTBENCH FAILED" sim.log; then
  exit 1
fi
if [ "$status" -ne 0 ] || ! grep -q "TESTBENCH PASSED" sim.log; then
  echo "simulation ended without a pass result"
  exit 1
fi

// ==== tb/rot_ref.svh ====
`ifndef ROT_REF_SVH
`define ROT_REF_SVH

// model state of the repetition test and the packer
rot_entropy_pkg::es_sample_t m_prev;
logic                        m_prev_valid;
int unsigned                 m_run;
int unsigned                 m_idx;
rot_entropy_pkg::es_word_t   m_word;
// words the endpoints should still receive, in order
rot_entropy_pkg::es_word_t   exp_words[$];
// health failures so far
int unsigned                 exp_fails;

// packing and run state back to idle
function automatic void model_clear();
  m_prev_valid = 1'b0;
  m_run        = 0;
  m_idx        = 0;
  m_word       = '0;
endfunction

// one accepted sample; a word is lost when the FIFO already holds depth words
function automatic void model_sample(rot_entropy_pkg::es_sample_t s, int unsigned limit,
                                     int depth);
  int unsigned run;
  if (m_prev_valid && (s == m_prev)) begin
    run = m_run + 1;
  end else begin
    run = 1;
  end
  if (run >= limit) begin
    // partial word thrown away, next sample counts as new
    exp_fails++;
    model_clear();
  end else begin
    m_prev       = s;
    m_prev_valid = 1'b1;
    m_run        = run;
    m_word[m_idx*rot_entropy_pkg::SampleWidth +: rot_entropy_pkg::SampleWidth] = s;
    if (m_idx == rot_entropy_pkg::SamplesPerWord - 1) begin
      if (exp_words.size() < depth) begin
        exp_words.push_back(m_word);
      end
      m_idx = 0;
    end else begin
      m_idx++;
    end
  end
endfunction

// round-robin pick, first candidate after the last grant, -1 if none
function automatic int rr_next(int last, logic [NumEp-1:0] cand);
  int idx;
  for (int i = 1; i <= NumEp; i++) begin
    idx = (last + i) % NumEp;
    if (cand[idx]) begin
      return idx;
    end
  end
  return -1;
endfunction

`endif

// ==== tb/rot_top_tb.sv ====
`timescale 1ns/1ps

module rot_top_tb;

  localparam int FifoDepth = 4;
  localparam int NumEp     = 4;

  logic                        clk;
  logic                        reset;
  logic                        bus_req;
  logic                        bus_we;
  rot_bus_pkg::bus_addr_t      bus_addr;
  rot_bus_pkg::bus_data_t      bus_wdata;
  logic                        bus_rvalid;
  rot_bus_pkg::bus_data_t      bus_rdata;
  logic                        rng_valid;
  rot_entropy_pkg::es_sample_t rng_sample;
  logic [NumEp-1:0]            ep_req;
  logic [NumEp-1:0]            ep_ack;
  rot_entropy_pkg::es_word_t   ep_data;
  logic                        intr_valid;
  logic                        intr_fail;

  integer                      seed;
  int unsigned                 err_cnt;
  int unsigned                 to_cnt;
  int unsigned                 thresh;
  // endpoint targets and words received
  int unsigned                 want [NumEp];
  int unsigned                 got [NumEp];
  int unsigned                 total_acks;
  int unsigned                 fail_pulses;
  int                          last_grant;
  logic [NumEp-1:0]            ack_prev;
  logic [NumEp-1:0]            cand_seen;
  logic                        active;
  // run tracking of the random source
  rot_entropy_pkg::es_sample_t gen_last;
  int unsigned                 gen_run;
  int unsigned                 acks_before;

  `include "rot_ref.svh"

  rot_top #(
    .EsFifoDepth  (FifoDepth),
    .NumEndPoints (NumEp)
  ) rot_top_inst (
    .clk_i                        (clk),
    .reset_i                      (reset),
    .bus_req_i                    (bus_req),
    .bus_we_i                     (bus_we),
    .bus_addr_i                   (bus_addr),
    .bus_wdata_i                  (bus_wdata),
    .bus_rvalid_o                 (bus_rvalid),
    .bus_rdata_o                  (bus_rdata),
    .rng_valid_i                  (rng_valid),
    .rng_sample_i                 (rng_sample),
    .ep_req_i                     (ep_req),
    .ep_ack_o                     (ep_ack),
    .ep_data_o                    (ep_data),
    .intr_es_entropy_valid_o      (intr_valid),
    .intr_es_health_test_failed_o (intr_fail)
  );

  always #2 clk = ~clk;

  // endpoints hold the request until acked, then drop it for a cycle
  always @(negedge clk) begin
    for (int i = 0; i < NumEp; i++) begin
      if (ep_ack[i]) begin
        got[i] = got[i] + 1;
        ep_req[i] = 1'b0;
      end else if (got[i] < want[i]) begin
        ep_req[i] = 1'b1;
      end
    end
  end

  // inputs taken at the rising edge, outputs at the falling edge
  always begin : compare_outputs
    int idx;
    int exp_idx;
    @(posedge clk);
    active = !reset;
    if (reset) begin
      last_grant = NumEp - 1;
      ack_prev   = '0;
    end else begin
      // the endpoint acked last cycle is not a candidate
      cand_seen = ep_req & ~ack_prev;
    end
    @(negedge clk);
    if (active) begin
      if (intr_fail) begin
        fail_pulses++;
      end
      assert ($onehot0(ep_ack)) else begin
        $display("FAIL %0t: acknowledge not one-hot, ack %b", $time, ep_ack);
        err_cnt++;
      end
      if (ep_ack != '0) begin
        idx = 0;
        for (int i = 0; i < NumEp; i++) begin
          if (ep_ack[i]) begin
            idx = i;
          end
        end
        exp_idx = rr_next(last_grant, cand_seen);
        assert (idx == exp_idx) else begin
          $display("FAIL %0t: acknowledge to endpoint %0d, expected %0d", $time, idx, exp_idx);
          err_cnt++;
        end
        assert (exp_words.size() != 0) else begin
          $display("acknowledge to endpoint %0d at %0t while no word was expected", idx, $time);
          err_cnt++;
        end
        if (exp_words.size() != 0) begin
          assert (ep_data == exp_words[0]) else begin
            $display("FAIL %0t: endpoint %0d got 0x%08h expected 0x%08h",
                     $time, idx, ep_data, exp_words[0]);
            err_cnt++;
          end
          void'(exp_words.pop_front());
        end
        last_grant = idx;
        total_acks++;
      end
      ack_prev = ep_ack;
    end
  end

  function automatic rot_bus_pkg::bus_addr_t es_reg_addr(rot_bus_pkg::reg_off_t off);
    return {rot_bus_pkg::SlvEntropySrc, off};
  endfunction

  function automatic rot_bus_pkg::bus_addr_t edn_reg_addr(rot_bus_pkg::reg_off_t off);
    return {rot_bus_pkg::SlvEdn, off};
  endfunction

  // one request, response expected exactly one cycle later
  task automatic bus_access(input logic we, input rot_bus_pkg::bus_addr_t addr,
                            input rot_bus_pkg::bus_data_t wdata,
                            output rot_bus_pkg::bus_data_t rdata);
    @(negedge clk);
    assert (!bus_rvalid) else begin
      $display("bus response present without a request at %0t", $time);
      err_cnt++;
    end
    bus_req   = 1'b1;
    bus_we    = we;
    bus_addr  = addr;
    bus_wdata = wdata;
    @(negedge clk);
    bus_req = 1'b0;
    bus_we  = 1'b0;
    assert (bus_rvalid) else begin
      $display("no bus response one cycle after the request to 0x%02h at %0t", addr, $time);
      err_cnt++;
    end
    rdata = bus_rdata;
    if (we) begin
      assert (bus_rdata == '0) else begin
        $display("FAIL %0t: write response data 0x%08h, expected zero", $time, bus_rdata);
        err_cnt++;
      end
    end
  endtask

  task automatic reg_write(input rot_bus_pkg::bus_addr_t addr,
                           input rot_bus_pkg::bus_data_t data);
    rot_bus_pkg::bus_data_t rd;
    bus_access(1'b1, addr, data, rd);
  endtask

  task automatic reg_check(input rot_bus_pkg::bus_addr_t addr,
                           input rot_bus_pkg::bus_data_t exp);
    rot_bus_pkg::bus_data_t rd;
    bus_access(1'b0, addr, '0, rd);
    assert (rd == exp) else begin
      $display("FAIL %0t: read 0x%02h got 0x%08h expected 0x%08h", $time, addr, rd, exp);
      err_cnt++;
    end
  endtask

  // sample offered at the falling edge, taken at the next rising edge
  task automatic feed(input rot_entropy_pkg::es_sample_t s);
    @(negedge clk);
    rng_valid  = 1'b1;
    rng_sample = s;
    model_sample(s, thresh, FifoDepth);
    if (s == gen_last) begin
      gen_run++;
    end else begin
      gen_run = 1;
    end
    gen_last = s;
  endtask

  task automatic feed_random(input int n);
    rot_entropy_pkg::es_sample_t s;
    for (int k = 0; k < n; k++) begin
      s = rot_entropy_pkg::es_sample_t'($random(seed));
      // break a run before it reaches the threshold
      if ((s == gen_last) && (gen_run + 1 >= thresh)) begin
        s = s + 1'b1;
      end
      feed(s);
    end
  endtask

  task automatic feed_run(input rot_entropy_pkg::es_sample_t v, input int len);
    for (int k = 0; k < len; k++) begin
      feed(v);
    end
  endtask

  task automatic stop_samples();
    @(negedge clk);
    rng_valid = 1'b0;
  endtask

  // targets change between falling edges
  task automatic request_words(input int ep, input int unsigned n);
    @(posedge clk);
    want[ep] = want[ep] + n;
  endtask

  task automatic stop_requests();
    @(posedge clk);
    for (int i = 0; i < NumEp; i++) begin
      want[i] = got[i];
    end
  endtask

  task automatic wait_drained(input int unsigned limit);
    int unsigned n;
    n = 0;
    while ((exp_words.size() != 0) && (n < limit)) begin
      @(posedge clk);
      n++;
    end
    if (exp_words.size() != 0) begin
      $display("timeout: %0d words still undelivered after %0d cycles", exp_words.size(), limit);
      to_cnt++;
    end
  endtask

  task automatic wait_acks(input int unsigned target, input int unsigned limit);
    int unsigned n;
    n = 0;
    while ((total_acks < target) && (n < limit)) begin
      @(posedge clk);
      n++;
    end
    if (total_acks < target) begin
      $display("timeout: %0d of %0d acknowledges seen after %0d cycles", total_acks, target, limit);
      to_cnt++;
    end
  endtask

  initial begin
    seed        = 32'hfe71;
    err_cnt     = 0;
    to_cnt      = 0;
    thresh      = 6;
    total_acks  = 0;
    fail_pulses = 0;
    exp_fails   = 0;
    gen_last    = '0;
    gen_run     = 0;
    clk         = 1'b0;
    reset       = 1'b1;
    bus_req     = 1'b0;
    bus_we      = 1'b0;
    bus_addr    = '0;
    bus_wdata   = '0;
    rng_valid   = 1'b0;
    rng_sample  = '0;
    ep_req      = '0;
    for (int i = 0; i < NumEp; i++) begin
      want[i] = 0;
      got[i]  = 0;
    end
    model_clear();
    repeat (4) @(negedge clk);
    reset = 1'b0;
    @(negedge clk);
    assert (!bus_rvalid && (ep_ack == '0) && !intr_valid && !intr_fail) else begin
      $display("outputs not low after reset at %0t", $time);
      err_cnt++;
    end

    // reset values, writable fields, read-only fields, unmapped space
    reg_check(es_reg_addr(rot_bus_pkg::EsCtrlOffset), 32'h0);
    reg_check(es_reg_addr(rot_bus_pkg::EsThreshOffset), 32'h6);
    reg_check(es_reg_addr(rot_bus_pkg::EsFailCntOffset), 32'h0);
    reg_check(es_reg_addr(rot_bus_pkg::EsLevelOffset), 32'h0);
    reg_check(edn_reg_addr(rot_bus_pkg::EdnCtrlOffset), 32'h0);
    reg_check(edn_reg_addr(rot_bus_pkg::EdnServedOffset), 32'h0);
    reg_write(es_reg_addr(rot_bus_pkg::EsThreshOffset), 32'hffff_fff9);
    reg_check(es_reg_addr(rot_bus_pkg::EsThreshOffset), 32'h9);
    reg_write(es_reg_addr(rot_bus_pkg::EsThreshOffset), 32'h6);
    reg_check(es_reg_addr(rot_bus_pkg::EsThreshOffset), 32'h6);
    reg_write(es_reg_addr(rot_bus_pkg::EsCtrlOffset), 32'h1);
    reg_check(es_reg_addr(rot_bus_pkg::EsCtrlOffset), 32'h1);
    reg_write(es_reg_addr(rot_bus_pkg::EsCtrlOffset), 32'h0);
    reg_check(es_reg_addr(rot_bus_pkg::EsCtrlOffset), 32'h0);
    reg_write(edn_reg_addr(rot_bus_pkg::EdnCtrlOffset), 32'hffff_ffff);
    reg_check(edn_reg_addr(rot_bus_pkg::EdnCtrlOffset), 32'h1);
    reg_write(edn_reg_addr(rot_bus_pkg::EdnCtrlOffset), 32'h0);
    reg_write(es_reg_addr(rot_bus_pkg::EsFailCntOffset), 32'hffff_ffff);
    reg_check(es_reg_addr(rot_bus_pkg::EsFailCntOffset), 32'h0);
    reg_write(es_reg_addr(rot_bus_pkg::EsLevelOffset), 32'hffff_ffff);
    reg_check(es_reg_addr(rot_bus_pkg::EsLevelOffset), 32'h0);
    reg_write(edn_reg_addr(rot_bus_pkg::EdnServedOffset), 32'hffff_ffff);
    reg_check(edn_reg_addr(rot_bus_pkg::EdnServedOffset), 32'h0);
    reg_check(8'h20, rot_bus_pkg::BusErrData);
    reg_check(8'hf4, rot_bus_pkg::BusErrData);
    reg_write(8'h30, 32'h1234_5678);

    // packing and delivery to one endpoint
    reg_write(es_reg_addr(rot_bus_pkg::EsCtrlOffset), 32'h1);
    reg_write(edn_reg_addr(rot_bus_pkg::EdnCtrlOffset), 32'h1);
    model_clear();
    request_words(0, 1000);
    feed_random(8 * 6);
    stop_samples();
    wait_drained(200);

    // runs below and at the threshold, one across a word boundary
    feed(4'ha);
    feed_run(4'h5, 5);
    feed(4'hb);
    feed_run(4'h5, 6);
    for (int k = 0; (k < 8) && (m_idx != 5); k++) begin
      feed_random(1);
    end
    feed(4'hc);
    feed_run(4'h3, 6);
    feed_random(8 * 3);
    stop_samples();
    wait_drained(200);
    reg_check(es_reg_addr(rot_bus_pkg::EsFailCntOffset), exp_fails);
    assert (fail_pulses == exp_fails) else begin
      $display("FAIL %0t: %0d health pulses, expected %0d", $time, fail_pulses, exp_fails);
      err_cnt++;
    end

    // overflow while nothing is delivered
    reg_write(edn_reg_addr(rot_bus_pkg::EdnCtrlOffset), 32'h0);
    stop_requests();
    feed_random(8 * (FifoDepth + 2));
    stop_samples();
    reg_check(es_reg_addr(rot_bus_pkg::EsLevelOffset), FifoDepth);
    assert (intr_valid) else begin
      $display("FAIL %0t: entropy valid interrupt low with a full FIFO", $time);
      err_cnt++;
    end
    reg_write(edn_reg_addr(rot_bus_pkg::EdnCtrlOffset), 32'h1);
    request_words(0, FifoDepth);
    wait_drained(200);
    reg_check(es_reg_addr(rot_bus_pkg::EsLevelOffset), 32'h0);

    // all endpoints compete, FIFO prefilled for back-to-back grants
    reg_write(edn_reg_addr(rot_bus_pkg::EdnCtrlOffset), 32'h0);
    feed_random(8 * FifoDepth + 8);
    stop_samples();
    for (int i = 0; i < NumEp; i++) begin
      request_words(i, 2);
    end
    acks_before = total_acks;
    reg_write(edn_reg_addr(rot_bus_pkg::EdnCtrlOffset), 32'h1);
    feed_random(8 * NumEp);
    stop_samples();
    wait_acks(acks_before + 2 * NumEp, 400);
    for (int i = 0; i < NumEp; i++) begin
      assert (got[i] == want[i]) else begin
        $display("FAIL %0t: endpoint %0d got %0d words, wanted %0d", $time, i, got[i], want[i]);
        err_cnt++;
      end
    end
    assert (exp_words.size() == 0) else begin
      $display("FAIL %0t: %0d expected words left over", $time, exp_words.size());
      err_cnt++;
    end
    reg_check(edn_reg_addr(rot_bus_pkg::EdnServedOffset), total_acks);

    $display("checks done: %0d value errors, %0d timeouts", err_cnt, to_cnt);
    if ((err_cnt == 0) && (to_cnt == 0)) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// ==== verilog/edn.sv ====
`timescale 1ns/1ps

module edn #(
  parameter int NumEndPoints = rot_entropy_pkg::NumEndPointsDefault
) (
  input  logic                      clk_i,
  input  logic                      reset_i,
  rot_reg_if.target                 reg_bus,
  input  rot_entropy_pkg::es_word_t es_word_i,
  input  logic                      es_empty_i,
  output logic                      es_pop_o,
  input  logic [NumEndPoints-1:0]   ep_req_i,
  output logic [NumEndPoints-1:0]   ep_ack_o,
  output rot_entropy_pkg::es_word_t ep_data_o
);

  localparam int IdxW = (NumEndPoints > 1) ? $clog2(NumEndPoints) : 1;

  logic                      enable_q;
  logic [15:0]               served_q;
  logic [IdxW-1:0]           last_q;
  logic [NumEndPoints-1:0]   ack_q;
  rot_entropy_pkg::es_word_t data_q;
  logic [NumEndPoints-1:0]   cand;
  logic [IdxW-1:0]           grant_idx;
  logic                      found;
  logic                      grant;
  logic                      reg_wr;

  assign reg_wr = reg_bus.req && reg_bus.we;

  // endpoint being acked this cycle still holds its request
  assign cand = ep_req_i & ~ack_q;

  // round-robin search from the slot after the last grant
  always_comb begin
    int unsigned idx;
    found     = 1'b0;
    grant_idx = '0;
    for (int unsigned i = 0; i < NumEndPoints; i++) begin
      idx = int'(last_q) + 1 + i;
      if (idx >= NumEndPoints) begin
        idx = idx - NumEndPoints;
      end
      if (!found && cand[idx]) begin
        found     = 1'b1;
        grant_idx = IdxW'(idx);
      end
    end
  end

  assign grant    = enable_q && !es_empty_i && found;
  // head word goes out with the pop
  assign es_pop_o = grant;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      enable_q <= 1'b0;
      served_q <= '0;
      // first search then starts at endpoint 0
      last_q   <= IdxW'(NumEndPoints - 1);
      ack_q    <= '0;
    end else begin
      ack_q <= '0;
      if (grant) begin
        ack_q[grant_idx] <= 1'b1;
        last_q           <= grant_idx;
        served_q         <= served_q + 1'b1;
      end
      if (reg_wr && (reg_bus.addr == rot_bus_pkg::EdnCtrlOffset)) begin
        enable_q <= reg_bus.wdata[0];
      end
    end
  end

  // word held next to the acknowledge
  always_ff @(posedge clk_i) begin
    if (grant) begin
      data_q <= es_word_i;
    end
  end

  always_comb begin
    reg_bus.rdata = '0;
    case (reg_bus.addr)
      rot_bus_pkg::EdnCtrlOffset:   reg_bus.rdata[0] = enable_q;
      rot_bus_pkg::EdnServedOffset: reg_bus.rdata[15:0] = served_q;
      default:                      reg_bus.rdata = '0;
    endcase
  end

  assign ep_ack_o  = ack_q;
  assign ep_data_o = data_q;

  // at most one endpoint served per cycle
  ack_onehot_a: assert property (@(posedge clk_i) disable iff (reset_i)
    $onehot0(ep_ack_o));

endmodule

// ==== verilog/entropy_src.sv ====
`timescale 1ns/1ps

module entropy_src #(
  parameter int EsFifoDepth = rot_entropy_pkg::EsFifoDepthDefault
) (
  input  logic                        clk_i,
  input  logic                        reset_i,
  rot_reg_if.target                   reg_bus,
  input  logic                        rng_valid_i,
  input  rot_entropy_pkg::es_sample_t rng_sample_i,
  input  logic                        es_pop_i,
  output rot_entropy_pkg::es_word_t   es_word_o,
  output logic                        es_empty_o,
  output logic                        intr_es_entropy_valid_o,
  output logic                        intr_es_health_test_failed_o
);

  localparam int IdxW = $clog2(rot_entropy_pkg::SamplesPerWord);
  localparam int LvlW = $clog2(EsFifoDepth + 1);
  localparam int SW   = rot_entropy_pkg::SampleWidth;

  logic                        enable_q;
  rot_entropy_pkg::rep_cnt_t   thresh_q;
  logic [15:0]                 fail_cnt_q;
  logic                        ht_intr_q;
  rot_entropy_pkg::es_sample_t prev_q;
  logic                        prev_valid_q;
  rot_entropy_pkg::rep_cnt_t   rep_cnt_q;
  rot_entropy_pkg::rep_cnt_t   rep_cnt_d;
  logic [IdxW-1:0]             pack_idx_q;
  rot_entropy_pkg::es_word_t   pack_q;
  rot_entropy_pkg::es_word_t   pack_d;
  logic                        sample_en;
  logic                        ht_fail;
  logic                        word_done;
  logic                        fifo_push;
  logic                        fifo_full;
  logic [LvlW-1:0]             fifo_level;
  logic                        reg_wr;

  assign sample_en = enable_q && rng_valid_i;
  assign reg_wr    = reg_bus.req && reg_bus.we;

  // repeat of the last sample extends the run, anything else restarts it
  always_comb begin
    if (prev_valid_q && (rng_sample_i == prev_q)) begin
      rep_cnt_d = rep_cnt_q + 1'b1;
    end else begin
      rep_cnt_d = rot_entropy_pkg::rep_cnt_t'(1);
    end
  end

  assign ht_fail = sample_en && (rep_cnt_d >= thresh_q);

  // new nibble lands above the ones already packed
  always_comb begin
    pack_d = pack_q;
    pack_d[pack_idx_q*SW +: SW] = rng_sample_i;
  end

  assign word_done = sample_en && !ht_fail &&
                     (pack_idx_q == IdxW'(rot_entropy_pkg::SamplesPerWord - 1));
  // a full FIFO drops the word
  assign fifo_push = word_done && !fifo_full;

  // run and packing state, cleared on disable or a failed test
  always_ff @(posedge clk_i) begin
    if (reset_i || !enable_q || ht_fail) begin
      prev_valid_q <= 1'b0;
      rep_cnt_q    <= '0;
      pack_idx_q   <= '0;
    end else if (sample_en) begin
      prev_valid_q <= 1'b1;
      rep_cnt_q    <= rep_cnt_d;
      pack_idx_q   <= word_done ? '0 : pack_idx_q + 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (sample_en) begin
      prev_q <= rng_sample_i;
      pack_q <= pack_d;
    end
  end

  // control registers, fail count and the health pulse
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      enable_q   <= 1'b0;
      thresh_q   <= rot_entropy_pkg::RepCntThreshDefault;
      fail_cnt_q <= '0;
      ht_intr_q  <= 1'b0;
    end else begin
      ht_intr_q <= ht_fail;
      if (ht_fail) begin
        fail_cnt_q <= fail_cnt_q + 1'b1;
      end
      if (reg_wr && (reg_bus.addr == rot_bus_pkg::EsCtrlOffset)) begin
        enable_q <= reg_bus.wdata[0];
      end
      if (reg_wr && (reg_bus.addr == rot_bus_pkg::EsThreshOffset)) begin
        thresh_q <= reg_bus.wdata[3:0];
      end
    end
  end

  // read mux, unused bits and offsets read zero
  always_comb begin
    reg_bus.rdata = '0;
    case (reg_bus.addr)
      rot_bus_pkg::EsCtrlOffset:    reg_bus.rdata[0] = enable_q;
      rot_bus_pkg::EsThreshOffset:  reg_bus.rdata[3:0] = thresh_q;
      rot_bus_pkg::EsFailCntOffset: reg_bus.rdata[15:0] = fail_cnt_q;
      rot_bus_pkg::EsLevelOffset:   reg_bus.rdata[LvlW-1:0] = fifo_level;
      default:                      reg_bus.rdata = '0;
    endcase
  end

  es_fifo #(
    .Depth (EsFifoDepth)
  ) u_es_fifo (
    .clk_i,
    .reset_i,
    .push_i  (fifo_push),
    .wdata_i (pack_d),
    .pop_i   (es_pop_i),
    .rdata_o (es_word_o),
    .full_o  (fifo_full),
    .empty_o (es_empty_o),
    .level_o (fifo_level)
  );

  assign intr_es_entropy_valid_o      = !es_empty_o;
  assign intr_es_health_test_failed_o = ht_intr_q;

endmodule

// ==== verilog/es_fifo.sv ====
`timescale 1ns/1ps

module es_fifo #(
  parameter int Depth = rot_entropy_pkg::EsFifoDepthDefault
) (
  input  logic                      clk_i,
  input  logic                      reset_i,
  input  logic                      push_i,
  input  rot_entropy_pkg::es_word_t wdata_i,
  input  logic                      pop_i,
  output rot_entropy_pkg::es_word_t rdata_o,
  output logic                      full_o,
  output logic                      empty_o,
  output logic [$clog2(Depth+1)-1:0] level_o
);

  localparam int PtrW = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int LvlW = $clog2(Depth + 1);

  rot_entropy_pkg::es_word_t mem_q [Depth];
  logic [PtrW-1:0]           wr_ptr_q;
  logic [PtrW-1:0]           rd_ptr_q;
  logic [LvlW-1:0]           level_q;

  // storage, no reset needed
  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= wdata_i;
    end
  end

  // pointers wrap at Depth, which need not be a power of two
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      level_q  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= (wr_ptr_q == PtrW'(Depth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop_i) begin
        rd_ptr_q <= (rd_ptr_q == PtrW'(Depth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      // level moves only when one side is active
      if (push_i && !pop_i) begin
        level_q <= level_q + 1'b1;
      end else if (pop_i && !push_i) begin
        level_q <= level_q - 1'b1;
      end
    end
  end

  // head word always visible
  assign rdata_o = mem_q[rd_ptr_q];
  assign full_o  = (level_q == LvlW'(Depth));
  assign empty_o = (level_q == '0);
  assign level_o = level_q;

  // producer and consumer must respect the flags
  no_push_full_a: assert property (@(posedge clk_i) disable iff (reset_i)
    push_i |-> !full_o);
  no_pop_empty_a: assert property (@(posedge clk_i) disable iff (reset_i)
    pop_i |-> !empty_o);

endmodule

// ==== verilog/rot_bus_pkg.sv ====
package rot_bus_pkg;

  // host bus widths
  localparam int BusAddrWidth = 8;
  localparam int BusDataWidth = 32;

  typedef logic [BusAddrWidth-1:0] bus_addr_t;
  typedef logic [BusDataWidth-1:0] bus_data_t;

  // register offset inside one block, low address nibble
  typedef logic [3:0] reg_off_t;

  // block select, taken from address bits 7:4
  localparam logic [3:0] SlvEntropySrc = 4'h0;
  localparam logic [3:0] SlvEdn        = 4'h1;

  // entropy source register map
  localparam reg_off_t EsCtrlOffset    = 4'h0;
  localparam reg_off_t EsThreshOffset  = 4'h4;
  localparam reg_off_t EsFailCntOffset = 4'h8;
  localparam reg_off_t EsLevelOffset   = 4'hC;

  // edn register map
  localparam reg_off_t EdnCtrlOffset   = 4'h0;
  localparam reg_off_t EdnServedOffset = 4'h4;

  // read value of an address that selects no block
  localparam bus_data_t BusErrData = 32'hDEADBEEF;

endpackage

// ==== verilog/rot_entropy_pkg.sv ====
package rot_entropy_pkg;

  // raw noise sample and packed word
  localparam int SampleWidth    = 4;
  localparam int SamplesPerWord = 8;

  typedef logic [SampleWidth-1:0]                es_sample_t;
  typedef logic [SampleWidth*SamplesPerWord-1:0] es_word_t;

  // repetition count and threshold share one width
  typedef logic [3:0] rep_cnt_t;

  // threshold after reset
  localparam rep_cnt_t RepCntThreshDefault = 4'd6;

  // sizing defaults for the top level
  localparam int EsFifoDepthDefault  = 4;
  localparam int NumEndPointsDefault = 4;

endpackage

// ==== verilog/rot_reg_if.sv ====
`timescale 1ns/1ps

interface rot_reg_if;

  // one-cycle access strobe
  logic                  req;
  logic                  we;
  // offset inside the selected block
  rot_bus_pkg::reg_off_t  addr;
  rot_bus_pkg::bus_data_t wdata;
  // combinational read data from the block
  rot_bus_pkg::bus_data_t rdata;

  // crossbar side
  modport host (
    output req, we, addr, wdata,
    input  rdata
  );

  // register block side
  modport target (
    input  req, we, addr, wdata,
    output rdata
  );

endinterface

// ==== verilog/rot_top.sv ====
`timescale 1ns/1ps

module rot_top #(
  parameter int EsFifoDepth  = rot_entropy_pkg::EsFifoDepthDefault,
  parameter int NumEndPoints = rot_entropy_pkg::NumEndPointsDefault
) (
  input  logic                        clk_i,
  input  logic                        reset_i,
  // host register bus
  input  logic                        bus_req_i,
  input  logic                        bus_we_i,
  input  rot_bus_pkg::bus_addr_t      bus_addr_i,
  input  rot_bus_pkg::bus_data_t      bus_wdata_i,
  output logic                        bus_rvalid_o,
  output rot_bus_pkg::bus_data_t      bus_rdata_o,
  // raw noise input
  input  logic                        rng_valid_i,
  input  rot_entropy_pkg::es_sample_t rng_sample_i,
  // hardware endpoints
  input  logic [NumEndPoints-1:0]     ep_req_i,
  output logic [NumEndPoints-1:0]     ep_ack_o,
  output rot_entropy_pkg::es_word_t   ep_data_o,
  // interrupts
  output logic                        intr_es_entropy_valid_o,
  output logic                        intr_es_health_test_failed_o
);

  rot_entropy_pkg::es_word_t es_word;
  logic                      es_empty;
  logic                      es_pop;

  // one register channel per block
  rot_reg_if u_es_reg ();
  rot_reg_if u_edn_reg ();

  rot_xbar u_xbar (
    .clk_i,
    .reset_i,
    .bus_req_i,
    .bus_we_i,
    .bus_addr_i,
    .bus_wdata_i,
    .bus_rvalid_o,
    .bus_rdata_o,
    .es_reg  (u_es_reg.host),
    .edn_reg (u_edn_reg.host)
  );

  entropy_src #(
    .EsFifoDepth (EsFifoDepth)
  ) u_entropy_src (
    .clk_i,
    .reset_i,
    .reg_bus     (u_es_reg.target),
    .rng_valid_i,
    .rng_sample_i,
    .es_pop_i    (es_pop),
    .es_word_o   (es_word),
    .es_empty_o  (es_empty),
    .intr_es_entropy_valid_o,
    .intr_es_health_test_failed_o
  );

  // conditioned words go straight from the FIFO to endpoints
  edn #(
    .NumEndPoints (NumEndPoints)
  ) u_edn (
    .clk_i,
    .reset_i,
    .reg_bus    (u_edn_reg.target),
    .es_word_i  (es_word),
    .es_empty_i (es_empty),
    .es_pop_o   (es_pop),
    .ep_req_i,
    .ep_ack_o,
    .ep_data_o
  );

endmodule

// ==== verilog/rot_xbar.sv ====
`timescale 1ns/1ps

module rot_xbar (
  input  logic                   clk_i,
  input  logic                   reset_i,
  input  logic                   bus_req_i,
  input  logic                   bus_we_i,
  input  rot_bus_pkg::bus_addr_t bus_addr_i,
  input  rot_bus_pkg::bus_data_t bus_wdata_i,
  output logic                   bus_rvalid_o,
  output rot_bus_pkg::bus_data_t bus_rdata_o,
  rot_reg_if.host                es_reg,
  rot_reg_if.host                edn_reg
);

  logic [3:0]             blk_sel;
  logic                   hit_es;
  logic                   hit_edn;
  rot_bus_pkg::bus_data_t rsp_data;

  // upper nibble picks the block
  assign blk_sel = bus_addr_i[rot_bus_pkg::BusAddrWidth-1:4];
  assign hit_es  = (blk_sel == rot_bus_pkg::SlvEntropySrc);
  assign hit_edn = (blk_sel == rot_bus_pkg::SlvEdn);

  // strobe goes only to the selected block
  assign es_reg.req    = bus_req_i && hit_es;
  assign es_reg.we     = bus_we_i;
  assign es_reg.addr   = bus_addr_i[3:0];
  assign es_reg.wdata  = bus_wdata_i;
  assign edn_reg.req   = bus_req_i && hit_edn;
  assign edn_reg.we    = bus_we_i;
  assign edn_reg.addr  = bus_addr_i[3:0];
  assign edn_reg.wdata = bus_wdata_i;

  // writes answer with zero
  always_comb begin
    if (bus_we_i) begin
      rsp_data = '0;
    end else if (hit_es) begin
      rsp_data = es_reg.rdata;
    end else if (hit_edn) begin
      rsp_data = edn_reg.rdata;
    end else begin
      rsp_data = rot_bus_pkg::BusErrData;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      bus_rvalid_o <= 1'b0;
    end else begin
      bus_rvalid_o <= bus_req_i;
    end
  end

  // response data only captured on a request
  always_ff @(posedge clk_i) begin
    if (bus_req_i) begin
      bus_rdata_o <= rsp_data;
    end
  end

  // every request answered in the next cycle, nothing else
  rvalid_after_req_a: assert property (@(posedge clk_i) disable iff (reset_i)
    bus_req_i |=> bus_rvalid_o);
  no_rvalid_without_req_a: assert property (@(posedge clk_i) disable iff (reset_i)
    !bus_req_i |=> !bus_rvalid_o);

endmodule
